//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // Datapath widths
  localparam int dbits      = 32;
  localparam int regno_bits = 4;
  localparam int imm_bits   = 16;

  localparam logic [dbits-1:0] inst_size = 32'd4;

  // Memory-mapped output port
  localparam logic [dbits-1:0] out_addr = 32'hFFFFF000;

  // Instruction field positions
  localparam int op1_hi = 31;
  localparam int op1_lo = 26;
  localparam int op2_hi = 25;
  localparam int op2_lo = 18;
  localparam int imm_hi = 23;
  localparam int imm_lo = 8;
  localparam int rd_hi  = 11;
  localparam int rd_lo  = 8;
  localparam int rs_hi  = 7;
  localparam int rs_lo  = 4;
  localparam int rt_hi  = 3;
  localparam int rt_lo  = 0;

  // Primary opcodes grouped by the upper bits
  typedef enum logic [5:0] {
    alur = 6'b000000,
    beq  = 6'b001000,
    blt  = 6'b001001,
    ble  = 6'b001010,
    bne  = 6'b001011,
    jal  = 6'b001100,
    lw   = 6'b010010,
    sw   = 6'b011010,
    addi = 6'b100000,
    andi = 6'b100100,
    ori  = 6'b100101,
    xori = 6'b100110
  } op1_e;

  // Secondary opcodes for register ALU operations
  typedef enum logic [7:0] {
    eq      = 8'b00001000,
    lt      = 8'b00001001,
    le      = 8'b00001010,
    ne      = 8'b00001011,
    add     = 8'b00100000,
    and_op  = 8'b00100100,
    or_op   = 8'b00100101,
    xor_op  = 8'b00100110,
    sub     = 8'b00101000,
    nand_op = 8'b00101100,
    nor_op  = 8'b00101101,
    nxor_op = 8'b00101110,
    rshf    = 8'b00110000,
    lshf    = 8'b00110001
  } op2_e;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
  parameter logic [dbits-1:0] start_pc = 32'h100,
  parameter int imem_addr_bits = 10
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      stall,
  input  wire                      mispred,
  input  wire [dbits-1:0]          pc_good,
  input  wire                      prog_we,
  input  wire [imem_addr_bits-3:0] prog_addr,
  input  wire [dbits-1:0]          prog_data,
  output logic [dbits-1:0]         inst_fe,
  output logic [dbits-1:0]         pc_next_fe
);

  localparam int imem_words = 1 << (imem_addr_bits - 2);

  logic [dbits-1:0] imem [imem_words];
  logic [dbits-1:0] pc;
  logic [dbits-1:0] pc_plus;
  logic [dbits-1:0] inst_rd;

  // Program load writes one word per strobe
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  assign inst_rd = imem[pc[imem_addr_bits-1:2]];
  assign pc_plus = pc + inst_size;

  // Redirect beats hold and hold beats sequential fetch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= start_pc;
    end else if (mispred) begin
      pc <= pc_good;
    end else if (!stall) begin
      pc <= pc_plus;
    end
  end

  // Fetch latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      inst_fe    <= '0;
      pc_next_fe <= '0;
    end else if (mispred) begin
      inst_fe    <= '0;
      pc_next_fe <= '0;
    end else if (!stall) begin
      inst_fe    <= inst_rd;
      pc_next_fe <= pc_plus;
    end
  end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
  input  wire                  clk,
  input  wire                  reset,
  input  wire [regno_bits-1:0] rs,
  input  wire [regno_bits-1:0] rt,
  input  wire                  wb_we,
  input  wire [regno_bits-1:0] wb_regno,
  input  wire [dbits-1:0]      wb_value,
  output logic [dbits-1:0]     rs_value,
  output logic [dbits-1:0]     rt_value
);

  localparam int nregs = 1 << regno_bits;

  logic [dbits-1:0] regs [nregs];

  // r0 is hardwired to zero
  assign rs_value = (rs == '0) ? '0 : regs[rs];
  assign rt_value = (rt == '0) ? '0 : regs[rt];

  // Falling-edge write lets decode read the new value in the same cycle
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_regno != '0) begin
      regs[wb_regno] <= wb_value;
    end
  end

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
  input  wire [regno_bits-1:0] rs,
  input  wire [regno_bits-1:0] rt,
  input  wire                  uses_rt,
  input  wire [regno_bits-1:0] ex_wregno,
  input  wire                  ex_wr_reg,
  input  wire [regno_bits-1:0] mem_wregno,
  input  wire                  mem_wr_reg,
  input  wire [regno_bits-1:0] wb_wregno,
  input  wire                  wb_wr_reg,
  output logic                 stall
);

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;

  // One in-flight destination against the decode sources
  function automatic logic dest_hit(
    input logic                  we,
    input logic [regno_bits-1:0] dst,
    input logic [regno_bits-1:0] src1,
    input logic [regno_bits-1:0] src2,
    input logic                  chk2
  );
    return we && (dst != '0) && ((dst == src1) || (chk2 && dst == src2));
  endfunction

  assign ex_hit  = dest_hit(ex_wr_reg, ex_wregno, rs, rt, uses_rt);
  assign mem_hit = dest_hit(mem_wr_reg, mem_wregno, rs, rt, uses_rt);
  assign wb_hit  = dest_hit(wb_wr_reg, wb_wregno, rs, rt, uses_rt);

  // Without forwarding any pending write holds decode
  assign stall = ex_hit || mem_hit || wb_hit;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   stall,
  input  wire                   mispred,
  input  wire [dbits-1:0]       inst_fe,
  input  wire [dbits-1:0]       pc_next_fe,
  input  wire [dbits-1:0]       rs_value,
  input  wire [dbits-1:0]       rt_value,
  output logic [regno_bits-1:0] rs,
  output logic [regno_bits-1:0] rt,
  output logic                  uses_rt,
  output op1_e                  id_op1,
  output op2_e                  id_op2,
  output logic [dbits-1:0]      id_val1,
  output logic [dbits-1:0]      id_val2,
  output logic [dbits-1:0]      id_imm,
  output logic [dbits-1:0]      id_pc_next,
  output logic [regno_bits-1:0] id_wregno,
  output logic                  id_is_br,
  output logic                  id_is_jmp,
  output logic                  id_rd_mem,
  output logic                  id_wr_mem,
  output logic                  id_wr_reg
);

  op1_e                  op1;
  op2_e                  op2;
  logic [imm_bits-1:0]   imm;
  logic [regno_bits-1:0] rd;
  logic [dbits-1:0]      sxt_imm;
  logic [regno_bits-1:0] wregno;
  logic                  is_br;
  logic                  is_jmp;
  logic                  rd_mem;
  logic                  wr_mem;
  logic                  wr_reg;

  // Field extraction
  assign op1 = op1_e'(inst_fe[op1_hi:op1_lo]);
  assign op2 = op2_e'(inst_fe[op2_hi:op2_lo]);
  assign imm = inst_fe[imm_hi:imm_lo];
  assign rd  = inst_fe[rd_hi:rd_lo];
  assign rs  = inst_fe[rs_hi:rs_lo];
  assign rt  = inst_fe[rt_hi:rt_lo];

  assign sxt_imm = {{(dbits - imm_bits){imm[imm_bits-1]}}, imm};

  // Only register ALU ops write rd
  assign wregno = (op1 == alur) ? rd : rt;

  // Control decode by opcode group
  always_comb begin
    is_br   = 1'b0;
    is_jmp  = 1'b0;
    rd_mem  = 1'b0;
    wr_mem  = 1'b0;
    wr_reg  = 1'b0;
    uses_rt = 1'b0;
    case (op1)
      alur: begin
        wr_reg  = 1'b1;
        uses_rt = 1'b1;
      end
      beq, blt, ble, bne: begin
        is_br   = 1'b1;
        uses_rt = 1'b1;
      end
      jal: begin
        is_jmp = 1'b1;
        wr_reg = 1'b1;
      end
      lw: begin
        rd_mem = 1'b1;
        wr_reg = 1'b1;
      end
      sw: begin
        wr_mem  = 1'b1;
        uses_rt = 1'b1;
      end
      addi, andi, ori, xori: begin
        wr_reg = 1'b1;
      end
      default: begin
        wr_reg = 1'b0;
      end
    endcase
  end

  // Decode latch loads a bubble on stall or redirect
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_op1     <= op1_e'(6'h00);
      id_op2     <= op2_e'(8'h00);
      id_val1    <= '0;
      id_val2    <= '0;
      id_imm     <= '0;
      id_pc_next <= '0;
      id_wregno  <= '0;
      id_is_br   <= 1'b0;
      id_is_jmp  <= 1'b0;
      id_rd_mem  <= 1'b0;
      id_wr_mem  <= 1'b0;
      id_wr_reg  <= 1'b0;
    end else if (stall || mispred) begin
      id_op1     <= op1_e'(6'h00);
      id_op2     <= op2_e'(8'h00);
      id_val1    <= '0;
      id_val2    <= '0;
      id_imm     <= '0;
      id_pc_next <= '0;
      id_wregno  <= '0;
      id_is_br   <= 1'b0;
      id_is_jmp  <= 1'b0;
      id_rd_mem  <= 1'b0;
      id_wr_mem  <= 1'b0;
      id_wr_reg  <= 1'b0;
    end else begin
      id_op1     <= op1;
      id_op2     <= op2;
      id_val1    <= rs_value;
      id_val2    <= rt_value;
      id_imm     <= sxt_imm;
      id_pc_next <= pc_next_fe;
      id_wregno  <= wregno;
      id_is_br   <= is_br;
      id_is_jmp  <= is_jmp;
      id_rd_mem  <= rd_mem;
      id_wr_mem  <= wr_mem;
      id_wr_reg  <= wr_reg;
    end
  end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  wire                   clk,
  input  wire                   reset,
  input  op1_e                  id_op1,
  input  op2_e                  id_op2,
  input  wire [dbits-1:0]       id_val1,
  input  wire [dbits-1:0]       id_val2,
  input  wire [dbits-1:0]       id_imm,
  input  wire [dbits-1:0]       id_pc_next,
  input  wire [regno_bits-1:0]  id_wregno,
  input  wire                   id_is_br,
  input  wire                   id_is_jmp,
  input  wire                   id_rd_mem,
  input  wire                   id_wr_mem,
  input  wire                   id_wr_reg,
  output logic                  mispred,
  output logic [dbits-1:0]      pc_good,
  output logic [dbits-1:0]      ex_alu_out,
  output logic [dbits-1:0]      ex_store_val,
  output logic [regno_bits-1:0] ex_wregno,
  output logic                  ex_rd_mem,
  output logic                  ex_wr_mem,
  output logic                  ex_wr_reg
);

  logic signed [dbits-1:0] a;
  logic signed [dbits-1:0] b;
  logic [dbits-1:0]        alu_res;
  logic [dbits-1:0]        target;
  logic                    br_cond;
  logic                    redirect;

  assign a = id_val1;
  assign b = id_val2;

  // --------------------------------------------------
  // Branch condition and target
  // --------------------------------------------------
  always_comb begin
    case (id_op1)
      beq:     br_cond = (a == b);
      blt:     br_cond = (a < b);
      ble:     br_cond = (a <= b);
      bne:     br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  // jal jumps relative to rs and branches relative to the next PC
  assign target   = (id_is_jmp ? id_val1 : id_pc_next) + (id_imm << 2);
  assign redirect = id_is_jmp || (id_is_br && br_cond);

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (id_op1)
      alur: begin
        case (id_op2)
          eq:      alu_res = {{(dbits-1){1'b0}}, a == b};
          lt:      alu_res = {{(dbits-1){1'b0}}, a < b};
          le:      alu_res = {{(dbits-1){1'b0}}, a <= b};
          ne:      alu_res = {{(dbits-1){1'b0}}, a != b};
          add:     alu_res = a + b;
          and_op:  alu_res = a & b;
          or_op:   alu_res = a | b;
          xor_op:  alu_res = a ^ b;
          sub:     alu_res = a - b;
          nand_op: alu_res = ~(a & b);
          nor_op:  alu_res = ~(a | b);
          nxor_op: alu_res = ~(a ^ b);
          rshf:    alu_res = a >>> id_val2;
          lshf:    alu_res = a << id_val2;
          default: alu_res = '0;
        endcase
      end
      // Address generation shares the adder with addi
      lw, sw, addi: alu_res = id_val1 + id_imm;
      andi:         alu_res = id_val1 & id_imm;
      ori:          alu_res = id_val1 | id_imm;
      xori:         alu_res = id_val1 ^ id_imm;
      jal:          alu_res = id_pc_next;
      default:      alu_res = '0;
    endcase
  end

  // Execute latch flushes for the cycle after a redirect
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mispred   <= 1'b0;
      ex_wregno <= '0;
      ex_rd_mem <= 1'b0;
      ex_wr_mem <= 1'b0;
      ex_wr_reg <= 1'b0;
    end else begin
      mispred   <= !mispred && redirect;
      ex_wregno <= mispred ? '0 : id_wregno;
      ex_rd_mem <= !mispred && id_rd_mem;
      ex_wr_mem <= !mispred && id_wr_mem;
      ex_wr_reg <= !mispred && id_wr_reg;
    end
  end

  always_ff @(posedge clk) begin
    pc_good      <= target;
    ex_alu_out   <= alu_res;
    ex_store_val <= id_val2;
  end

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; #(
  parameter int dmem_addr_bits = 10
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire [dbits-1:0]       ex_alu_out,
  input  wire [dbits-1:0]       ex_store_val,
  input  wire [regno_bits-1:0]  ex_wregno,
  input  wire                   ex_rd_mem,
  input  wire                   ex_wr_mem,
  input  wire                   ex_wr_reg,
  output logic                  wb_we,
  output logic [regno_bits-1:0] wb_regno,
  output logic [dbits-1:0]      wb_value,
  output logic                  out_strobe,
  output logic [dbits-1:0]      out_data
);

  localparam int dmem_words = 1 << (dmem_addr_bits - 2);

  logic [dbits-1:0]          dmem [dmem_words];
  logic [dmem_addr_bits-3:0] word_addr;
  logic [dbits-1:0]          rd_data;
  logic                      is_out;

  assign word_addr = ex_alu_out[dmem_addr_bits-1:2];
  assign rd_data   = dmem[word_addr];
  assign is_out    = (ex_alu_out == out_addr);

  // Stores to the output address leave the core instead of memory
  assign out_strobe = ex_wr_mem && is_out;
  assign out_data   = ex_store_val;

  always_ff @(posedge clk) begin
    if (ex_wr_mem && !is_out) begin
      dmem[word_addr] <= ex_store_val;
    end
  end

  // Writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_we    <= 1'b0;
      wb_regno <= '0;
    end else begin
      wb_we    <= ex_wr_reg;
      wb_regno <= ex_wregno;
    end
  end

  always_ff @(posedge clk) begin
    wb_value <= ex_rd_mem ? rd_data : ex_alu_out;
  end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter logic [dbits-1:0] start_pc = 32'h100,
  parameter int imem_addr_bits = 10,
  parameter int dmem_addr_bits = 10
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      prog_we,
  input  wire [imem_addr_bits-3:0] prog_addr,
  input  wire [dbits-1:0]          prog_data,
  output logic                     out_strobe,
  output logic [dbits-1:0]         out_data
);

  // Fetch to decode
  logic [dbits-1:0] inst_fe;
  logic [dbits-1:0] pc_next_fe;

  // Decode sources and hazard control
  logic [regno_bits-1:0] rs;
  logic [regno_bits-1:0] rt;
  logic [dbits-1:0]      rs_value;
  logic [dbits-1:0]      rt_value;
  logic                  uses_rt;
  logic                  stall;

  // Decode to execute
  op1_e                  id_op1;
  op2_e                  id_op2;
  logic [dbits-1:0]      id_val1;
  logic [dbits-1:0]      id_val2;
  logic [dbits-1:0]      id_imm;
  logic [dbits-1:0]      id_pc_next;
  logic [regno_bits-1:0] id_wregno;
  logic                  id_is_br;
  logic                  id_is_jmp;
  logic                  id_rd_mem;
  logic                  id_wr_mem;
  logic                  id_wr_reg;

  // Execute to memory and the redirect path
  logic                  mispred;
  logic [dbits-1:0]      pc_good;
  logic [dbits-1:0]      ex_alu_out;
  logic [dbits-1:0]      ex_store_val;
  logic [regno_bits-1:0] ex_wregno;
  logic                  ex_rd_mem;
  logic                  ex_wr_mem;
  logic                  ex_wr_reg;

  // Writeback
  logic                  wb_we;
  logic [regno_bits-1:0] wb_regno;
  logic [dbits-1:0]      wb_value;

  // --------------------------------------------------
  // Front end
  // --------------------------------------------------
  fetch_stage #(
    .start_pc       (start_pc),
    .imem_addr_bits (imem_addr_bits)
  ) u_fetch (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .mispred    (mispred),
    .pc_good    (pc_good),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .inst_fe    (inst_fe),
    .pc_next_fe (pc_next_fe)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .mispred    (mispred),
    .inst_fe    (inst_fe),
    .pc_next_fe (pc_next_fe),
    .rs_value   (rs_value),
    .rt_value   (rt_value),
    .rs         (rs),
    .rt         (rt),
    .uses_rt    (uses_rt),
    .id_op1     (id_op1),
    .id_op2     (id_op2),
    .id_val1    (id_val1),
    .id_val2    (id_val2),
    .id_imm     (id_imm),
    .id_pc_next (id_pc_next),
    .id_wregno  (id_wregno),
    .id_is_br   (id_is_br),
    .id_is_jmp  (id_is_jmp),
    .id_rd_mem  (id_rd_mem),
    .id_wr_mem  (id_wr_mem),
    .id_wr_reg  (id_wr_reg)
  );

  register_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs       (rs),
    .rt       (rt),
    .wb_we    (wb_we),
    .wb_regno (wb_regno),
    .wb_value (wb_value),
    .rs_value (rs_value),
    .rt_value (rt_value)
  );

  // Destinations held in the decode, execute and writeback latches
  hazard_unit u_hazard (
    .rs         (rs),
    .rt         (rt),
    .uses_rt    (uses_rt),
    .ex_wregno  (id_wregno),
    .ex_wr_reg  (id_wr_reg),
    .mem_wregno (ex_wregno),
    .mem_wr_reg (ex_wr_reg),
    .wb_wregno  (wb_regno),
    .wb_wr_reg  (wb_we),
    .stall      (stall)
  );

  // --------------------------------------------------
  // Back end
  // --------------------------------------------------
  execute_stage u_execute (
    .clk          (clk),
    .reset        (reset),
    .id_op1       (id_op1),
    .id_op2       (id_op2),
    .id_val1      (id_val1),
    .id_val2      (id_val2),
    .id_imm       (id_imm),
    .id_pc_next   (id_pc_next),
    .id_wregno    (id_wregno),
    .id_is_br     (id_is_br),
    .id_is_jmp    (id_is_jmp),
    .id_rd_mem    (id_rd_mem),
    .id_wr_mem    (id_wr_mem),
    .id_wr_reg    (id_wr_reg),
    .mispred      (mispred),
    .pc_good      (pc_good),
    .ex_alu_out   (ex_alu_out),
    .ex_store_val (ex_store_val),
    .ex_wregno    (ex_wregno),
    .ex_rd_mem    (ex_rd_mem),
    .ex_wr_mem    (ex_wr_mem),
    .ex_wr_reg    (ex_wr_reg)
  );

  memory_stage #(
    .dmem_addr_bits (dmem_addr_bits)
  ) u_memory (
    .clk          (clk),
    .reset        (reset),
    .ex_alu_out   (ex_alu_out),
    .ex_store_val (ex_store_val),
    .ex_wregno    (ex_wregno),
    .ex_rd_mem    (ex_rd_mem),
    .ex_wr_mem    (ex_wr_mem),
    .ex_wr_reg    (ex_wr_reg),
    .wb_we        (wb_we),
    .wb_regno     (wb_regno),
    .wb_value     (wb_value),
    .out_strobe   (out_strobe),
    .out_data     (out_data)
  );

endmodule

`default_nettype wire

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam logic [dbits-1:0] start_pc = 32'h100;
  localparam int imem_addr_bits = 10;
  localparam int dmem_addr_bits = 10;
  localparam int paw            = imem_addr_bits - 2;
  localparam int half_period    = 4;
  localparam int max_rows       = 32;
  localparam int row_words      = 8;
  // Nops past the program cover the speculative fetches behind the self-loop
  localparam int load_words     = 12;
  localparam int run_limit      = 150;
  localparam int cycles_per_row = 200;
  localparam logic [15:0] out_off = 16'hF000;

  logic             clk;
  logic             reset;
  logic             prog_we;
  logic [paw-1:0]   prog_addr;
  logic [dbits-1:0] prog_data;
  logic             out_strobe;
  logic [dbits-1:0] out_data;

  // Program table with one row per test program
  logic [dbits-1:0] prog_words [max_rows][row_words];
  logic [dbits-1:0] expected [max_rows];
  int               nrows;
  int               errors;
  int               checks;
  integer           seed;
  logic             table_ready;

  cpu_top #(
    .start_pc       (start_pc),
    .imem_addr_bits (imem_addr_bits),
    .dmem_addr_bits (dmem_addr_bits)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .out_strobe (out_strobe),
    .out_data   (out_data)
  );

  always #half_period clk = ~clk;

  // --------------------------------------------------
  // Instruction encoding
  // --------------------------------------------------
  function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] reg_instr(input op2_e op, input logic [3:0] rd,
                                            input logic [3:0] rs, input logic [3:0] rt);
    return {alur, op, 6'b000000, rd, rs, rt};
  endfunction

  function automatic logic [31:0] imm_instr(input op1_e op, input logic [3:0] rt,
                                            input logic [3:0] rs, input logic [15:0] imm);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  // --------------------------------------------------
  // Reference results from the instruction set rules
  // --------------------------------------------------
  function automatic logic [31:0] alu_expect(input op2_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
      eq:      return (a == b) ? 32'd1 : 32'd0;
      lt:      return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      le:      return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      ne:      return (a != b) ? 32'd1 : 32'd0;
      add:     return a + b;
      and_op:  return a & b;
      or_op:   return a | b;
      xor_op:  return a ^ b;
      sub:     return a - b;
      nand_op: return ~(a & b);
      nor_op:  return ~(a | b);
      nxor_op: return ~(a ^ b);
      rshf:    return $signed(a) >>> b;
      lshf:    return a << b;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] imm_expect(input op1_e op, input logic [31:0] a,
                                             input logic [31:0] imm);
    case (op)
      addi:    return a + imm;
      andi:    return a & imm;
      ori:     return a | imm;
      xori:    return a ^ imm;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(input op1_e op, input logic [31:0] a,
                                        input logic [31:0] b);
    case (op)
      beq:     return a == b;
      blt:     return $signed(a) < $signed(b);
      ble:     return $signed(a) <= $signed(b);
      bne:     return a != b;
      default: return 1'b0;
    endcase
  endfunction

  // --------------------------------------------------
  // Table rows
  // --------------------------------------------------
  // Store to the output address and spin on beq r0,r0,-1
  task automatic close_row(input int n, input logic [3:0] src, input logic [31:0] value);
    prog_words[nrows][n]     = imm_instr(sw, src, 4'd0, out_off);
    prog_words[nrows][n + 1] = imm_instr(beq, 4'd0, 4'd0, 16'hFFFF);
    expected[nrows]          = value;
    nrows++;
  endtask

  task automatic alu_row(input op2_e op);
    logic [15:0] a;
    logic [15:0] b;
    a = 16'($random(seed));
    b = 16'($random(seed));
    if (op == eq || op == le) begin
      b = a;
    end
    if (op == rshf || op == lshf) begin
      b = b & 16'h001f;
    end
    prog_words[nrows][0] = imm_instr(addi, 4'd1, 4'd0, a);
    prog_words[nrows][1] = imm_instr(ori, 4'd2, 4'd0, b);
    prog_words[nrows][2] = reg_instr(op, 4'd3, 4'd1, 4'd2);
    close_row(3, 4'd3, alu_expect(op, sext(a), sext(b)));
  endtask

  // Negative immediate to show sign extension
  task automatic imm_op_row(input op1_e op);
    logic [15:0] a;
    logic [15:0] imm;
    a   = 16'($random(seed));
    imm = 16'($random(seed)) | 16'h8000;
    prog_words[nrows][0] = imm_instr(addi, 4'd1, 4'd0, a);
    prog_words[nrows][1] = imm_instr(op, 4'd2, 4'd1, imm);
    close_row(2, 4'd2, imm_expect(op, sext(a), sext(imm)));
  endtask

  task automatic load_store_row();
    logic [15:0] a;
    a = 16'($random(seed));
    prog_words[nrows][0] = imm_instr(addi, 4'd1, 4'd0, a);
    prog_words[nrows][1] = imm_instr(addi, 4'd2, 4'd0, 16'h0040);
    prog_words[nrows][2] = imm_instr(sw, 4'd1, 4'd2, 16'd8);
    prog_words[nrows][3] = imm_instr(lw, 4'd4, 4'd2, 16'd8);
    close_row(4, 4'd4, sext(a));
  endtask

  // Each instruction needs the result of the one right before it
  task automatic dependency_row();
    logic [15:0] a;
    a = 16'($random(seed));
    prog_words[nrows][0] = imm_instr(addi, 4'd1, 4'd0, a);
    prog_words[nrows][1] = reg_instr(add, 4'd5, 4'd1, 4'd1);
    prog_words[nrows][2] = reg_instr(add, 4'd6, 4'd5, 4'd1);
    close_row(3, 4'd6, sext(a) + sext(a) + sext(a));
  endtask

  // Taken branch skips two writes to r3
  task automatic branch_row(input op1_e op, input logic [15:0] a, input logic [15:0] b);
    logic [15:0] x;
    x = 16'($random(seed));
    prog_words[nrows][0] = imm_instr(addi, 4'd1, 4'd0, a);
    prog_words[nrows][1] = imm_instr(addi, 4'd2, 4'd0, b);
    prog_words[nrows][2] = imm_instr(addi, 4'd3, 4'd0, x);
    prog_words[nrows][3] = imm_instr(op, 4'd2, 4'd1, 16'd2);
    prog_words[nrows][4] = imm_instr(addi, 4'd3, 4'd0, x + 16'd1);
    prog_words[nrows][5] = imm_instr(addi, 4'd3, 4'd0, x + 16'd2);
    close_row(6, 4'd3, branch_taken(op, sext(a), sext(b)) ? sext(x) : sext(x + 16'd2));
  endtask

  // jal at word 1 jumps to word 4 and links its PC plus 4
  task automatic link_row();
    prog_words[nrows][0] = imm_instr(addi, 4'd1, 4'd0, start_pc[15:0]);
    prog_words[nrows][1] = imm_instr(jal, 4'd2, 4'd1, 16'd4);
    prog_words[nrows][2] = imm_instr(addi, 4'd2, 4'd0, 16'h0011);
    prog_words[nrows][3] = imm_instr(addi, 4'd2, 4'd0, 16'h0022);
    close_row(4, 4'd2, start_pc + 32'd8);
  endtask

  task automatic build_table();
    logic [15:0] a;
    logic [15:0] b;
    for (int r = 0; r < max_rows; r++) begin
      for (int i = 0; i < row_words; i++) begin
        prog_words[r][i] = '0;
      end
      expected[r] = '0;
    end
    alu_row(eq);
    alu_row(lt);
    alu_row(le);
    alu_row(ne);
    alu_row(add);
    alu_row(and_op);
    alu_row(or_op);
    alu_row(xor_op);
    alu_row(sub);
    alu_row(nand_op);
    alu_row(nor_op);
    alu_row(nxor_op);
    alu_row(rshf);
    alu_row(lshf);
    imm_op_row(addi);
    imm_op_row(andi);
    imm_op_row(ori);
    imm_op_row(xori);
    load_store_row();
    dependency_row();
    a = 16'($random(seed));
    b = 16'($random(seed));
    if (b == a) begin
      b = a + 16'd1;
    end
    // Both outcomes of every branch
    branch_row(beq, a, a);
    branch_row(beq, a, b);
    branch_row(bne, a, b);
    branch_row(bne, a, a);
    branch_row(blt, a, b);
    branch_row(blt, b, a);
    branch_row(ble, a, a);
    branch_row(ble, a, b);
    branch_row(ble, b, a);
    link_row();
  endtask

  // --------------------------------------------------
  // Load, run and check one program
  // --------------------------------------------------
  task automatic run_row(input int r);
    logic got;
    int   waited;
    got    = 1'b0;
    waited = 0;
    reset  = 1'b1;
    for (int i = 0; i < load_words; i++) begin
      prog_we   = 1'b1;
      prog_addr = paw'(int'(start_pc[imem_addr_bits-1:2]) + i);
      if (i < row_words) begin
        prog_data = prog_words[r][i];
      end else begin
        prog_data = '0;
      end
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    while (!got && waited < run_limit) begin
      @(negedge clk);
      waited++;
      if (out_strobe) begin
        got = 1'b1;
      end
    end
    checks++;
    if (!got) begin
      errors++;
      $display("row %0d: no store to the output address within %0d cycles", r, run_limit);
    end else if (out_data !== expected[r]) begin
      errors++;
      $display("error: out_data row %0d expected %08h actual %08h", r, expected[r], out_data);
    end
    // Only one output store per program
    if (got) begin
      repeat (8) begin
        @(negedge clk);
        if (out_strobe) begin
          errors++;
          $display("row %0d: a second output store followed the first one", r);
        end
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    errors      = 0;
    checks      = 0;
    nrows       = 0;
    seed        = 12612;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(negedge clk);
    for (int r = 0; r < nrows; r++) begin
      run_row(r);
    end
    $display("Rows: %0d, checks: %0d, errors: %0d", nrows, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized by the number of programs
  initial begin
    wait (table_ready);
    repeat (nrows * cycles_per_row) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish",
             nrows * cycles_per_row);
    $display("Rows: %0d, checks: %0d, errors: %0d", nrows, checks, errors + 1);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
testbench/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
RTL_TOP   ?= cpu_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
